// File: spu_core.f
logic/spu_pkg.sv
logic/spu_cfg_regs.sv
logic/spu_op_add.sv
logic/spu_op_logic.sv
logic/spu_core.sv
sim/spu_core_asserts.sv
sim/spu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module spu_core_tb --Mdir "$BUILD" \
    -f spu_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/Vspu_core_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "no pass line found in $LOG"
exit 1

// File: sim/spu_core_tb.sv
`timescale 1ns/1ns

module spu_core_tb;

    logic                clk;
    logic                reset;
    logic                cke;
    spu_pkg::spu_in_t    in;
    logic                cfg_req;
    spu_pkg::cfg_addr_t  cfg_addr;
    spu_pkg::data_t      cfg_wdata;
    logic                cfg_ack;
    spu_pkg::add_out_t   add_out;
    spu_pkg::logic_out_t logic_out;

    spu_core spu_core_i (.*);

    // --------------------
    // reference model state
    // --------------------
    spu_pkg::spu_cfg_t   m_cfg;     // model copy of the config registers
    logic                m_carry;   // model chain carry
    spu_pkg::add_out_t   add_q[$];
    spu_pkg::logic_out_t logic_q[$];
    int                  add_due_q[$];     // enabled cycle each result is due
    int                  logic_due_q[$];
    spu_pkg::add_out_t   add_seen[$];      // adder results in arrival order
    int                  en_cnt = 0;       // enabled edges since reset
    string               test_name = "reset";
    int                  phase_items = 40;
    int                  chain_pairs = 20;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_add(input spu_pkg::add_out_t exp, input spu_pkg::add_out_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf(
                "[ERROR] %s add_out expected %h carry %b msb_c %b, actual %h carry %b msb_c %b",
                test_name, exp.data, exp.carry, exp.msb_c, act.data, act.carry, act.msb_c));
        end
    endtask

    task automatic check_logic(input spu_pkg::logic_out_t exp, input spu_pkg::logic_out_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] %s logic_out expected data=%h, actual data=%h",
                test_name, exp.data, act.data));
        end
    endtask

    task automatic check_arrival(input string unit, input int due);
        if (en_cnt != due) begin
            stop_with_failure($sformatf("%s: %s result came at enabled cycle %0d, not at %0d",
                test_name, unit, en_cnt, due));
        end
    endtask

    // expected results for one accepted item
    function automatic void model_accept(input spu_pkg::spu_in_t item);
        logic [spu_pkg::DATA_BITS:0] sum;
        logic [spu_pkg::DATA_BITS:0] c;
        logic                        cin;
        spu_pkg::add_out_t           a;
        spu_pkg::logic_out_t         l;
        cin = m_cfg.chain ? m_carry : item.carry;
        sum = {1'b0, item.data0} + {1'b0, item.data1} + {{spu_pkg::DATA_BITS{1'b0}}, cin};
        c   = sum ^ {1'b0, item.data0} ^ {1'b0, item.data1};   // carry into each bit
        a   = '{carry: c[spu_pkg::DATA_BITS], msb_c: c[spu_pkg::DATA_BITS-1],
                data: spu_pkg::data_t'(sum), valid: 1'b1};
        case (m_cfg.logic_op)
            spu_pkg::OP_AND: l.data = item.data0 & item.data1;
            spu_pkg::OP_OR:  l.data = item.data0 | item.data1;
            spu_pkg::OP_XOR: l.data = item.data0 ^ item.data1;
            default:         l.data = item.data0 & ~item.data1;
        endcase
        l.valid = 1'b1;
        if (item.clear) begin
            a = '{carry: m_cfg.clear_carry, msb_c: m_cfg.clear_msb_c,
                  data: m_cfg.clear_data, valid: 1'b1};
            l.data = m_cfg.clear_data;
        end
        m_carry = a.carry;
        add_q.push_back(a);
        add_due_q.push_back(en_cnt + spu_pkg::ADD_LATENCY);
        logic_q.push_back(l);
        logic_due_q.push_back(en_cnt + spu_pkg::LOGIC_LATENCY);
    endfunction

    // --------------------
    // output monitor
    // --------------------
    always @(negedge clk) begin
        if (!reset && cke) begin   // one check per enabled cycle
            if (add_out.valid && add_q.size() == 0) begin
                stop_with_failure("adder gave a valid result with no item outstanding");
            end else if (add_out.valid) begin
                check_add(add_q.pop_front(), add_out);
                check_arrival("adder", add_due_q.pop_front());
                add_seen.push_back(add_out);
            end
            if (logic_out.valid && logic_q.size() == 0) begin
                stop_with_failure("logic operator gave a valid result with no item outstanding");
            end else if (logic_out.valid) begin
                check_logic(logic_q.pop_front(), logic_out);
                check_arrival("logic", logic_due_q.pop_front());
            end
            if (in.valid) model_accept(in);
            en_cnt++;
        end
    end

    function automatic spu_pkg::data_t pick_operand();
        spu_pkg::data_t one_hot;
        one_hot = spu_pkg::data_t'(1) << ($urandom % spu_pkg::DATA_BITS);
        case ($urandom % 7)
            0: return '0;
            1: return '1;
            2: return {1'b1, {(spu_pkg::DATA_BITS-1){1'b0}}};   // signed min
            3: return {1'b0, {(spu_pkg::DATA_BITS-1){1'b1}}};   // signed max
            4: return one_hot;
            5: return ~one_hot;
            default: return spu_pkg::data_t'($urandom);
        endcase
    endfunction

    function automatic spu_pkg::spu_in_t random_item(input int clear_odds);
        spu_pkg::spu_in_t item;
        item.carry = ($urandom % 2) != 0;
        item.data0 = pick_operand();
        item.data1 = pick_operand();
        item.clear = ($urandom % clear_odds) == 0;
        item.valid = ($urandom % 4) != 0;
        return item;
    endfunction

    // hold the item until an enabled cycle takes it
    task automatic send_item(input spu_pkg::spu_in_t item);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            in  <= item;
            cke <= ($urandom % 10) != 0;   // stall one cycle in ten
            @(negedge clk);
            taken = cke;
        end
    endtask

    task automatic drain_pipes();
        @(posedge clk);
        in.valid <= 1'b0;
        while (add_q.size() != 0 || logic_q.size() != 0) begin
            @(posedge clk);
            cke <= ($urandom % 10) != 0;
        end
    endtask

    task automatic run_items(input string name, input int count, input int clear_odds);
        test_name = name;
        repeat (count) send_item(random_item(clear_odds));
        drain_pipes();
    endtask

    // --------------------
    // config bus master
    // --------------------
    task automatic cfg_write(input spu_pkg::cfg_addr_t addr, input spu_pkg::data_t data);
        @(posedge clk);
        cfg_req   <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(negedge clk);
        if (cfg_ack) stop_with_failure("cfg_ack was high before the request was seen");
        @(negedge clk);
        if (!cfg_ack) stop_with_failure("cfg_ack did not rise one cycle after cfg_req");
        @(posedge clk);
        cfg_req <= 1'b0;
        @(negedge clk);
        if (!cfg_ack) stop_with_failure("cfg_ack fell while cfg_req was still high");
        @(negedge clk);
        if (cfg_ack) stop_with_failure("cfg_ack did not fall one cycle after cfg_req dropped");
        case (addr)
            spu_pkg::CFG_CLEAR_DATA: m_cfg.clear_data = data;
            spu_pkg::CFG_FLAGS:    {m_cfg.chain, m_cfg.clear_msb_c, m_cfg.clear_carry} = data[2:0];
            spu_pkg::CFG_LOGIC_OP: m_cfg.logic_op = spu_pkg::logic_op_e'(data[1:0]);
            default: ;   // address 3 stores nothing
        endcase
    endtask

    // clear, low word, high word, then compare against a 16-bit sum
    task automatic run_chain(input int pairs);
        logic [2*spu_pkg::DATA_BITS-1:0] a[$];
        logic [2*spu_pkg::DATA_BITS-1:0] b[$];
        logic [2*spu_pkg::DATA_BITS:0]   s;
        logic [2*spu_pkg::DATA_BITS:0]   c;
        spu_pkg::add_out_t               want;
        test_name = "chained_add";
        add_seen.delete();
        for (int k = 0; k < pairs; k++) begin
            a.push_back({pick_operand(), pick_operand()});
            b.push_back({pick_operand(), pick_operand()});
            send_item(spu_pkg::spu_in_t'{carry: 1'b1, data0: '0, data1: '0,
                                          clear: 1'b1, valid: 1'b1});
            send_item(spu_pkg::spu_in_t'{carry: 1'b1, data0: spu_pkg::data_t'(a[k]),
                data1: spu_pkg::data_t'(b[k]), clear: 1'b0, valid: 1'b1});
            send_item(spu_pkg::spu_in_t'{carry: 1'b0,
                data0: spu_pkg::data_t'(a[k] >> spu_pkg::DATA_BITS),
                data1: spu_pkg::data_t'(b[k] >> spu_pkg::DATA_BITS), clear: 1'b0, valid: 1'b1});
        end
        drain_pipes();
        test_name = "chained_vs_wide";
        if (add_seen.size() != 3 * pairs) stop_with_failure("chained phase lost adder results");
        for (int k = 0; k < pairs; k++) begin
            s = {1'b0, a[k]} + {1'b0, b[k]};
            c = s ^ {1'b0, a[k]} ^ {1'b0, b[k]};
            want = '{carry: c[spu_pkg::DATA_BITS], msb_c: c[spu_pkg::DATA_BITS-1],
                     data: spu_pkg::data_t'(s), valid: 1'b1};
            check_add(want, add_seen[3*k+1]);
            want = '{carry: c[2*spu_pkg::DATA_BITS], msb_c: c[2*spu_pkg::DATA_BITS-1],
                     data: spu_pkg::data_t'(s >> spu_pkg::DATA_BITS), valid: 1'b1};
            check_add(want, add_seen[3*k+2]);
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        void'($urandom(22));
        reset     = 1'b1;
        cke       = 1'b0;
        in        = '0;
        cfg_req   = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        m_cfg     = '{clear_data: '1, clear_carry: 1'b1, clear_msb_c: 1'b0,
                      chain: 1'b0, logic_op: spu_pkg::OP_AND};
        m_carry   = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (add_out.valid || logic_out.valid || cfg_ack) begin
            stop_with_failure("outputs were not idle after reset");
        end
        test_name = "reset_defaults";
        send_item(spu_pkg::spu_in_t'{carry: 1'b0, data0: '0, data1: '0, clear: 1'b1, valid: 1'b1});
        drain_pipes();
        run_items("unchained_add", phase_items, 8);
        cfg_write(2'd3, 8'h56);   // would set chain if it landed
        run_items("addr3_ignored", phase_items, 8);
        cfg_write(spu_pkg::CFG_CLEAR_DATA, 8'h5a);
        cfg_write(spu_pkg::CFG_FLAGS, 8'h02);
        run_items("clear_values", phase_items, 3);
        for (int op = 1; op <= 4; op++) begin
            cfg_write(spu_pkg::CFG_LOGIC_OP, spu_pkg::data_t'(op % 4));
            run_items($sformatf("logic_op_%0d", op % 4), phase_items, 8);
        end
        cfg_write(spu_pkg::CFG_FLAGS, 8'h04);   // chain on, clear carry 0
        run_chain(chain_pairs);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog sized from the planned item and config counts
    initial begin
        int limit;
        limit = (7 * phase_items + 1 + 3 * chain_pairs) * 20 + 8 * 20 + 16;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", limit);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

endmodule

// File: sim/spu_core_asserts.sv
`timescale 1ns/1ns

module spu_core_asserts (
    input logic clk,
    input logic reset,
    input logic cfg_req,
    input logic cfg_ack
);

    // --------------------
    // config handshake
    // --------------------
    ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req))
    else $error("cfg_ack rose with no request pending");

    ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(cfg_ack) |-> !$past(cfg_req))
    else $error("cfg_ack fell while cfg_req was still high");

    ack_low_after_reset: assert property (@(posedge clk) reset |=> !cfg_ack)
    else $error("cfg_ack high in the cycle after reset");

endmodule

bind spu_cfg_regs spu_core_asserts cfg_asserts_i (
    .clk     (clk),
    .reset   (reset),
    .cfg_req (cfg_req),
    .cfg_ack (cfg_ack)
);

// File: logic/spu_core.sv
`timescale 1ns/1ns

module spu_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                cke,
    input  spu_pkg::spu_in_t    in,
    input  logic                cfg_req,
    input  spu_pkg::cfg_addr_t  cfg_addr,
    input  spu_pkg::data_t      cfg_wdata,
    output logic                cfg_ack,
    output spu_pkg::add_out_t   add_out,
    output spu_pkg::logic_out_t logic_out
);

    spu_pkg::spu_cfg_t cfg;   // shared by both operators

    // --------------------
    // config bus slave
    // --------------------
    spu_cfg_regs spu_cfg_regs_i (
        .clk       (clk),
        .reset     (reset),
        .cfg_req   (cfg_req),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg       (cfg)
    );

    // --------------------
    // operators
    // --------------------
    spu_op_add spu_op_add_i (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .in      (in),
        .cfg     (cfg),
        .add_out (add_out)
    );

    spu_op_logic spu_op_logic_i (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .in        (in),      // same stream as the adder
        .cfg       (cfg),
        .logic_out (logic_out)
    );

endmodule

// File: logic/spu_op_logic.sv
`timescale 1ns/1ns

module spu_op_logic (
    input  logic                clk,
    input  logic                reset,
    input  logic                cke,
    input  spu_pkg::spu_in_t    in,
    input  spu_pkg::spu_cfg_t   cfg,
    output spu_pkg::logic_out_t logic_out
);

    spu_pkg::data_t op_result;
    spu_pkg::data_t out_data;
    logic           out_valid;

    // --------------------
    // bitwise function
    // --------------------
    always_comb begin
        case (cfg.logic_op)
            spu_pkg::OP_AND:  op_result = in.data0 & in.data1;
            spu_pkg::OP_OR:   op_result = in.data0 | in.data1;
            spu_pkg::OP_XOR:  op_result = in.data0 ^ in.data1;
            spu_pkg::OP_ANDN: op_result = in.data0 & ~in.data1;
            default:          op_result = in.data0 & in.data1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_data  <= '0;
            out_valid <= 1'b0;
        end else if (cke) begin
            out_valid <= in.valid;
            if (in.valid) begin
                out_data <= in.clear ? cfg.clear_data : op_result;   // clear wins
            end
        end
    end

    assign logic_out = '{data: out_data, valid: out_valid};

endmodule

// File: logic/spu_op_add.sv
`timescale 1ns/1ns

module spu_op_add (
    input  logic              clk,
    input  logic              reset,
    input  logic              cke,
    input  spu_pkg::spu_in_t  in,
    input  spu_pkg::spu_cfg_t cfg,
    output spu_pkg::add_out_t add_out
);

    logic [spu_pkg::ADD_LATENCY-1:0] valid_sr;   // one bit per stage

    logic                       carry_in;
    logic [spu_pkg::DATA_BITS:0]   sum_full;     // carry out on top
    logic [spu_pkg::DATA_BITS-1:0] sum_low;      // low bits only, for msb_c

    logic           carry_q;   // stage 1 carry, also the chain carry
    spu_pkg::data_t s1_data;
    logic           s1_msb_c;

    spu_pkg::data_t out_data;
    logic           out_carry;
    logic           out_msb_c;

    // --------------------
    // stage 1 arithmetic
    // --------------------
    assign carry_in = cfg.chain ? carry_q : in.carry;

    assign sum_full = {1'b0, in.data0}
                    + {1'b0, in.data1}
                    + {{spu_pkg::DATA_BITS{1'b0}}, carry_in};

    // the MSB carry is the carry out of the lower DATA_BITS-1 bits
    assign sum_low = {1'b0, in.data0[spu_pkg::DATA_BITS-2:0]}
                   + {1'b0, in.data1[spu_pkg::DATA_BITS-2:0]}
                   + {{(spu_pkg::DATA_BITS-1){1'b0}}, carry_in};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
            carry_q  <= 1'b0;
        end else if (cke) begin
            valid_sr <= {valid_sr[spu_pkg::ADD_LATENCY-2:0], in.valid};
            if (in.valid) begin
                carry_q <= in.clear ? cfg.clear_carry : sum_full[spu_pkg::DATA_BITS];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cke && in.valid) begin
            if (in.clear) begin
                s1_data  <= cfg.clear_data;
                s1_msb_c <= cfg.clear_msb_c;
            end else begin
                s1_data  <= sum_full[spu_pkg::DATA_BITS-1:0];
                s1_msb_c <= sum_low[spu_pkg::DATA_BITS-1];
            end
        end
    end

    // --------------------
    // stage 2 output
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_data  <= '0;
            out_carry <= 1'b0;
            out_msb_c <= 1'b0;
        end else if (cke && valid_sr[0]) begin   // holds between items
            out_data  <= s1_data;
            out_carry <= carry_q;
            out_msb_c <= s1_msb_c;
        end
    end

    assign add_out = '{
        carry: out_carry,
        msb_c: out_msb_c,
        data:  out_data,
        valid: valid_sr[spu_pkg::ADD_LATENCY-1]
    };

endmodule

// File: logic/spu_cfg_regs.sv
`timescale 1ns/1ns

module spu_cfg_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               cfg_req,
    input  spu_pkg::cfg_addr_t cfg_addr,
    input  spu_pkg::data_t     cfg_wdata,
    output logic               cfg_ack,
    output spu_pkg::spu_cfg_t  cfg
);

    spu_pkg::cfg_state_e state;

    // --------------------
    // four-phase slave
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= spu_pkg::CFG_IDLE;
        end else begin
            case (state)
                spu_pkg::CFG_IDLE: begin
                    if (cfg_req) begin
                        state <= spu_pkg::CFG_ACK;   // write lands this edge
                    end
                end
                spu_pkg::CFG_ACK: begin
                    if (cfg_req) begin
                        state <= spu_pkg::CFG_WAIT_REL;
                    end else begin
                        state <= spu_pkg::CFG_IDLE;
                    end
                end
                spu_pkg::CFG_WAIT_REL: begin
                    if (!cfg_req) begin
                        state <= spu_pkg::CFG_IDLE;
                    end
                end
                default: state <= spu_pkg::CFG_IDLE;
            endcase
        end
    end

    assign cfg_ack = (state != spu_pkg::CFG_IDLE);   // straight from the state reg

    // --------------------
    // register writes
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.clear_data  <= '1;
            cfg.clear_carry <= 1'b1;
            cfg.clear_msb_c <= 1'b0;
            cfg.chain       <= 1'b0;
            cfg.logic_op    <= spu_pkg::OP_AND;
        end else if (state == spu_pkg::CFG_IDLE && cfg_req) begin
            case (cfg_addr)
                spu_pkg::CFG_CLEAR_DATA: cfg.clear_data <= cfg_wdata;
                spu_pkg::CFG_FLAGS: begin
                    cfg.clear_carry <= cfg_wdata[0];
                    cfg.clear_msb_c <= cfg_wdata[1];
                    cfg.chain       <= cfg_wdata[2];
                end
                spu_pkg::CFG_LOGIC_OP: cfg.logic_op <= spu_pkg::logic_op_e'(cfg_wdata[1:0]);
                default: ;   // addr 3, acked and dropped
            endcase
        end
    end

endmodule

// File: logic/spu_pkg.sv
package spu_pkg;

    // --------------------
    // widths and latencies
    // --------------------
    localparam int DATA_BITS     = 8;
    localparam int ADD_LATENCY   = 2;   // enabled cycles, in -> add_out
    localparam int LOGIC_LATENCY = 1;   // enabled cycles, in -> logic_out
    localparam int CFG_ADDR_BITS = 2;

    typedef logic [DATA_BITS-1:0]     data_t;
    typedef logic [CFG_ADDR_BITS-1:0] cfg_addr_t;

    // config register map, address 3 is a no-op write
    localparam cfg_addr_t CFG_CLEAR_DATA = 2'd0;
    localparam cfg_addr_t CFG_FLAGS      = 2'd1;
    localparam cfg_addr_t CFG_LOGIC_OP   = 2'd2;

    typedef enum logic [1:0] {
        OP_AND  = 2'd0,
        OP_OR   = 2'd1,
        OP_XOR  = 2'd2,
        OP_ANDN = 2'd3     // data0 & ~data1
    } logic_op_e;

    typedef enum logic [1:0] {
        CFG_IDLE     = 2'd0,
        CFG_ACK      = 2'd1,   // write done, ack up
        CFG_WAIT_REL = 2'd2    // ack held until req drops
    } cfg_state_e;

    // --------------------
    // stream and config items
    // --------------------
    typedef struct packed {
        logic  carry;
        data_t data0;
        data_t data1;
        logic  clear;
        logic  valid;
    } spu_in_t;

    typedef struct packed {
        logic  carry;
        logic  msb_c;      // carry into the top bit
        data_t data;
        logic  valid;
    } add_out_t;

    typedef struct packed {
        data_t data;
        logic  valid;
    } logic_out_t;

    typedef struct packed {
        data_t     clear_data;
        logic      clear_carry;
        logic      clear_msb_c;
        logic      chain;
        logic_op_e logic_op;
    } spu_cfg_t;

endpackage
